// File: logic/fpuDecode.sv
/*
  FPU decode stage
  Maps OP-FP encodings to an operation, reads the FP register file with
  bypass from execute and loads the decode/execute register
*/
`include "fpu_defines.svh"

module fpuDecode import fpuPkg::*; (
  input  logic              clk,
  input  logic              arstN,
  input  logic              instrValid,   // Instruction strobe
  input  logic [`ILEN-1:0]  instr,
  input  intWordT           intSrc,       // Integer operand for fmv.w.x
  decodeExecIf.decode       de,
  execResultIf.bypass       byp
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  regAdrT     rs1, rs2, rd;
  fpOpE       op;                         // Decoded operation
  fpWordT     regFile [`NREGS];           // 32 x 32 FP registers
  fpWordT     xRead, yRead;               // Operands after bypass

  assign opcode = instr[`F_OPC];
  assign funct7 = instr[`F_FUNCT7];
  assign funct3 = instr[`F_FUNCT3];
  assign rs1    = instr[`F_RS1];
  assign rs2    = instr[`F_RS2];
  assign rd     = instr[`F_RD];

  //////////////////////////////////////////////////////////////////////
  // Instruction decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    op = opNone;                          // Anything unmatched is illegal
    if (opcode == `OPFP) begin
      case (funct7)
        `F7_FSGNJ: begin
          case (funct3)
            3'd0:    op = opSgnj;
            3'd1:    op = opSgnjn;
            3'd2:    op = opSgnjx;
            default: op = opNone;
          endcase
        end
        `F7_FMINMAX: begin
          if (funct3 == 3'd0)      op = opMin;
          else if (funct3 == 3'd1) op = opMax;
        end
        `F7_FCMP: begin
          case (funct3)
            3'd2:    op = opEq;
            3'd1:    op = opLt;
            3'd0:    op = opLe;
            default: op = opNone;
          endcase
        end
        `F7_FMVXW: begin
          // Single-source group, rs2 must be zero
          if (rs2 == '0 && funct3 == 3'd0)      op = opMvXW;
          else if (rs2 == '0 && funct3 == 3'd1) op = opClass;
        end
        `F7_FMVWX: begin
          if (rs2 == '0 && funct3 == 3'd0) op = opMvWX;
        end
        default: op = opNone;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register file, written at the end of the execute cycle
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `NREGS; i++) begin
        regFile[i] <= '0;
      end
    end else if (byp.valid && byp.fpWrite) begin
      regFile[byp.rd] <= byp.fpValue;       // x0 is an ordinary FP register
    end
  end

  // Forward the execute result when it targets a source register
  assign xRead = (byp.valid && byp.fpWrite && byp.rd == rs1) ? byp.fpValue : regFile[rs1];
  assign yRead = (byp.valid && byp.fpWrite && byp.rd == rs2) ? byp.fpValue : regFile[rs2];

  // Decode/execute register, control part
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      de.valid <= 1'b0;
      de.op    <= opNone;
      de.rd    <= '0;
    end else begin
      de.valid <= instrValid;
      if (instrValid) begin
        de.op <= op;
        de.rd <= rd;
      end
    end
  end

  // Operand payload
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      de.x      <= '0;
      de.y      <= '0;
      de.intSrc <= '0;
    end else if (instrValid) begin
      de.x      <= xRead;
      de.y      <= yRead;
      de.intSrc <= intSrc;
    end
  end

endmodule

// File: logic/fpuExecute.sv
/*
  FPU execute stage
  Unpacks and classifies both operands, then forms sign injection,
  compare, min/max, fclass and move results with the NV flag
*/
`include "fpu_defines.svh"

module fpuExecute import fpuPkg::*; (
  decodeExecIf.execute  de,
  execResultIf.execute  res
);

  classMaskT        xCls, yCls;         // One-hot class of each operand
  logic             xNaN, yNaN;
  logic             xSNaN, ySNaN;
  logic             bothZero;           // +0 and -0 compare equal
  logic [`FLEN-2:0] xMag, yMag;         // Exponent and fraction
  logic             ordLt;              // x below y, -0 below +0
  logic             isEq, isLt;         // IEEE ordered results
  fpWordT           minMax;
  logic             invalid;            // NV for this operation

  // Split into sign, exponent, fraction and return the fclass mask
  function automatic classMaskT classify(fpWordT v);
    logic           sign;
    logic [`NE-1:0] expo;
    logic [`NF-1:0] frac;
    int             idx;
    classMaskT      m;
    sign = v[`FLEN-1];
    expo = v[`FLEN-2 -: `NE];
    frac = v[`NF-1:0];
    if (&expo && frac != '0) idx = frac[`NF-1] ? 9 : 8;   // Quiet or signaling NaN
    else if (&expo)          idx = sign ? 0 : 7;          // Infinity
    else if (expo != '0)     idx = sign ? 1 : 6;          // Normal
    else if (frac != '0)     idx = sign ? 2 : 5;          // Subnormal
    else                     idx = sign ? 3 : 4;          // Zero
    m = '0;
    m[idx] = 1'b1;
    return m;
  endfunction

  assign xCls     = classify(de.x);
  assign yCls     = classify(de.y);
  assign xNaN     = xCls[9] | xCls[8];
  assign yNaN     = yCls[9] | yCls[8];
  assign xSNaN    = xCls[8];
  assign ySNaN    = yCls[8];
  assign bothZero = (xCls[3] | xCls[4]) & (yCls[3] | yCls[4]);
  assign xMag     = de.x[`FLEN-2:0];
  assign yMag     = de.y[`FLEN-2:0];

  //////////////////////////////////////////////////////////////////////
  // Compare and min/max
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    if (de.x[`FLEN-1] != de.y[`FLEN-1]) ordLt = de.x[`FLEN-1];   // Negative side is less
    else if (de.x[`FLEN-1])             ordLt = xMag > yMag;     // Both negative
    else                                ordLt = xMag < yMag;
  end

  assign isEq = ~(xNaN | yNaN) & ((de.x == de.y) | bothZero);
  assign isLt = ~(xNaN | yNaN) & ordLt & ~bothZero;

  always_comb begin
    if (xNaN && yNaN)         minMax = `CANON_NAN;
    else if (xNaN)            minMax = de.y;      // Single NaN yields the other operand
    else if (yNaN)            minMax = de.x;
    else if (de.op == opMax)  minMax = ordLt ? de.y : de.x;
    else                      minMax = ordLt ? de.x : de.y;
  end

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    res.fpWrite  = 1'b0;
    res.intWrite = 1'b0;
    res.fpValue  = de.x;
    res.intValue = '0;
    invalid      = 1'b0;
    case (de.op)
      opSgnj:  begin res.fpWrite = 1'b1; res.fpValue = {de.y[`FLEN-1], xMag};  end
      opSgnjn: begin res.fpWrite = 1'b1; res.fpValue = {~de.y[`FLEN-1], xMag}; end
      opSgnjx: begin
        res.fpWrite = 1'b1;
        res.fpValue = {de.x[`FLEN-1] ^ de.y[`FLEN-1], xMag};
      end
      opMin, opMax: begin
        res.fpWrite = 1'b1;
        res.fpValue = minMax;
        invalid     = xSNaN | ySNaN;
      end
      opEq: begin
        res.intWrite = 1'b1;
        res.intValue = intWordT'(isEq);
        invalid      = xSNaN | ySNaN;          // Quiet compare
      end
      opLt: begin
        res.intWrite = 1'b1;
        res.intValue = intWordT'(isLt);
        invalid      = xNaN | yNaN;            // Signaling compare
      end
      opLe: begin
        res.intWrite = 1'b1;
        res.intValue = intWordT'(isLt | isEq);
        invalid      = xNaN | yNaN;
      end
      opClass: begin res.intWrite = 1'b1; res.intValue = intWordT'(xCls); end
      opMvXW:  begin res.intWrite = 1'b1; res.intValue = de.x;            end
      opMvWX:  begin res.fpWrite = 1'b1;  res.fpValue = de.intSrc;        end
      default: ;                               // opNone writes nothing
    endcase
  end

  always_comb begin
    res.flags            = '0;
    res.flags[`FLAG_NV]  = invalid;          // Only NV can arise here
  end

  assign res.valid   = de.valid;
  assign res.rd      = de.rd;
  assign res.illegal = (de.op == opNone);

endmodule

// File: logic/fpuIf.sv
/*
  FPU stage interfaces
  Decode to execute operands, execute to result and bypass
*/

// Decode/execute pipeline register contents
interface decodeExecIf import fpuPkg::*; ();
  logic     valid;   // Item present in execute
  fpOpE     op;
  regAdrT   rd;      // Destination FP register
  fpWordT   x;       // rs1 value after bypass
  fpWordT   y;       // rs2 value after bypass
  intWordT  intSrc;  // Integer source for fmv.w.x

  modport decode  (output valid, op, rd, x, y, intSrc);
  modport execute (input  valid, op, rd, x, y, intSrc);
endinterface

// Execute outputs, seen by the result stage and the register file
interface execResultIf import fpuPkg::*; ();
  logic     valid;
  regAdrT   rd;
  logic     fpWrite;   // Write fpValue to FP register rd
  fpWordT   fpValue;
  logic     intWrite;  // intValue goes to the integer side
  intWordT  intValue;
  fflagsT   flags;     // Exception flags of this item
  logic     illegal;   // Unsupported encoding

  modport execute (output valid, rd, fpWrite, fpValue, intWrite, intValue, flags, illegal);
  modport result  (input  valid, rd, fpWrite, fpValue, intWrite, intValue, flags, illegal);
  modport bypass  (input  valid, rd, fpWrite, fpValue);  // Regfile write and forwarding
endinterface

// File: logic/fpuPkg.sv
/*
  FPU type package
  Word, address, flag and class types plus the operation enum
*/
`include "fpu_defines.svh"

package fpuPkg;

  typedef logic [`FLEN-1:0]           fpWordT;     // One FP register value
  typedef logic [`XLEN-1:0]           intWordT;    // Integer-side value
  typedef logic [$clog2(`NREGS)-1:0]  regAdrT;     // FP register address
  typedef logic [4:0]                 fflagsT;     // NV DZ OF UF NX
  typedef logic [`NCLASS-1:0]         classMaskT;  // fclass one-hot

  //////////////////////////////////////////////////////////////////////
  // Operation selected in decode, consumed in execute
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    opNone,     // Unsupported encoding, flagged illegal
    opSgnj,     // Copy sign of y
    opSgnjn,    // Inverted sign of y
    opSgnjx,    // Sign x xor sign y
    opMin,
    opMax,
    opEq,       // Quiet compare
    opLt,       // Signaling compare
    opLe,       // Signaling compare
    opClass,    // fclass.s
    opMvXW,     // FP bits to integer
    opMvWX      // Integer bits to FP
  } fpOpE;

endpackage

// File: logic/fpuResult.sv
/*
  FPU result stage
  Registers integer results, per-instruction flags and the illegal pulse,
  and keeps the sticky fflags accumulator
*/

module fpuResult import fpuPkg::*; (
  input  logic          clk,
  input  logic          arstN,
  execResultIf.result   res,
  output logic          intResultValid,  // Strobe for intResult
  output intWordT       intResult,
  output fflagsT        fflagsSet,       // Flags raised by this result
  output logic          illegalInstr,    // One-cycle pulse
  output fflagsT        fflags           // Sticky accumulator
);

  logic intItem;  // Valid item bound for the integer side

  assign intItem = res.valid & res.intWrite;

  // Control and flag registers
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      intResultValid <= 1'b0;
      fflagsSet      <= '0;
      illegalInstr   <= 1'b0;
      fflags         <= '0;
    end else begin
      intResultValid <= intItem;
      // Per-instruction flags ride with integer results, FP writes reach only the sticky set
      fflagsSet      <= intItem ? res.flags : '0;
      illegalInstr   <= res.valid & res.illegal;
      if (res.valid) begin
        fflags <= fflags | res.flags;   // Bits stay set until reset
      end
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (intItem) begin
      intResult <= res.intValue;
    end
  end

endmodule

// File: logic/fpuTop.sv
/*
  Single-precision FPU top
  Three-stage decode, execute and result pipeline for the
  non-arithmetic OP-FP instructions
*/
`include "fpu_defines.svh"

module fpuTop import fpuPkg::*; (
  input  logic              clk,
  input  logic              arstN,
  input  logic              instrValid,      // Instruction strobe
  input  logic [`ILEN-1:0]  instr,
  input  intWordT           intSrc,          // rs1 value from the integer side
  output logic              intResultValid,
  output intWordT           intResult,
  output fflagsT            fflagsSet,
  output fflagsT            fflags,
  output logic              illegalInstr
);

  decodeExecIf deIf ();   // Decode/execute register
  execResultIf erIf ();   // Execute outputs

  // Decode, register file and bypass
  fpuDecode uDecode (
    .clk, .arstN, .instrValid, .instr, .intSrc,
    .de  (deIf.decode),
    .byp (erIf.bypass)
  );

  // Combinational execute units
  fpuExecute uExecute (
    .de  (deIf.execute),
    .res (erIf.execute)
  );

  // Output registers and sticky flags
  fpuResult uResult (
    .clk, .arstN,
    .res (erIf.result),
    .intResultValid, .intResult, .fflagsSet, .illegalInstr, .fflags
  );

endmodule

// File: logic/fpu_defines.svh
/*
  FPU shared constants
  Word widths, instruction field positions and OP-FP encodings
*/
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

`define FLEN      32              // FP register width
`define XLEN      32              // Integer register width
`define ILEN      32              // Instruction width
`define NREGS     32              // FP register count
`define NE        8               // Exponent bits, single precision
`define NF        23              // Fraction bits, single precision
`define NCLASS    10              // fclass mask bits
`define FLAG_NV   4               // Invalid-operation bit in fflags
`define CANON_NAN 32'h7FC0_0000   // Canonical quiet NaN

// Instruction fields
`define F_OPC     6:0
`define F_RD      11:7
`define F_FUNCT3  14:12
`define F_RS1     19:15
`define F_RS2     24:20
`define F_FUNCT7  31:25

// OP-FP major opcode and funct7 groups
`define OPFP        7'b1010011
`define F7_FSGNJ    7'b0010000
`define F7_FMINMAX  7'b0010100
`define F7_FCMP     7'b1010000
`define F7_FMVXW    7'b1110000    // Shared with fclass, split by funct3
`define F7_FMVWX    7'b1111000

`endif

// File: project.f
+incdir+logic
logic/fpuPkg.sv
logic/fpuIf.sv
logic/fpuDecode.sv
logic/fpuExecute.sv
logic/fpuResult.sv
logic/fpuTop.sv
testbench/fpuSva.sv
testbench/fpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the FPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module fpuTb --Mdir obj_dir -o fpuSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fpuSim +verilator+error+limit+1000 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
  exit 1
fi
if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
exit 0

// File: testbench/fpuSva.sv
/*
  FPU output assertions
  Output exclusivity, sticky flags and fclass masks, bound to fpuTop
*/
`include "fpu_defines.svh"

module fpuSva import fpuPkg::*; (
  input logic             clk,
  input logic             arstN,
  input logic             instrValid,
  input logic [`ILEN-1:0] instr,
  input logic             intResultValid,
  input intWordT          intResult,
  input fflagsT           fflagsSet,
  input fflagsT           fflags,
  input logic             illegalInstr
);
  timeunit 1ns;
  timeprecision 100ps;

  int   failCount = 0;   // Assertion failures so far
  logic classIssued;     // fclass.s sampled this cycle

  assign classIssued = instrValid && instr[`F_OPC] == `OPFP && instr[`F_FUNCT7] == `F7_FMVXW
                       && instr[`F_FUNCT3] == 3'd1 && instr[`F_RS2] == '0;

  exclusiveOut: assert property (@(posedge clk) disable iff (!arstN)
    !(intResultValid && illegalInstr))
    else begin failCount++; $error("intResultValid and illegalInstr both high"); end

  stickyFlags: assert property (@(posedge clk) disable iff (!arstN)
    (fflags & $past(fflags)) == $past(fflags))
    else begin failCount++; $error("fflags lost a set bit"); end

  quietFlags: assert property (@(posedge clk) disable iff (!arstN)
    !intResultValid && !illegalInstr |-> fflagsSet == '0)
    else begin failCount++; $error("fflagsSet nonzero without a result"); end

  // Result shows up in the sample two edges after issue
  classOneHot: assert property (@(posedge clk) disable iff (!arstN)
    intResultValid && $past(classIssued, 2) |-> $onehot(intResult))
    else begin failCount++; $error("fclass result is not one-hot"); end

endmodule

bind fpuTop fpuSva sva (.*);

// File: testbench/fpuTb.sv
/*
  FPU testbench
  Drives OP-FP instructions on the falling edge and predicts every
  output with a reference model, then checks it two cycles later
*/
`include "fpu_defines.svh"

module fpuTb import fpuPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NSPEC  = 12;                       // Special operand values
  localparam int NRAND  = 300;                      // Random mixed instructions
  localparam int NSTEPS = 100 + NSPEC * NSPEC * 13 + 2 * NSPEC + 2 * NRAND;
  localparam fpWordT SPEC [NSPEC] = '{
    32'h0000_0000, 32'h8000_0000, 32'h3F80_0000, 32'hBF80_0000,   // +-0, +-1.0
    32'h0000_0001, 32'h8040_0000, 32'h7F80_0000, 32'hFF80_0000,   // Subnormals, infinities
    32'h7FC0_0000, 32'h7F80_0001, 32'hFFC0_0001, 32'h4000_0000    // qNaN, sNaN, -qNaN, 2.0
  };

  typedef struct packed {
    logic    vld;      // Integer result expected
    intWordT val;
    fflagsT  set;
    logic    ill;
    fflagsT  sticky;   // Accumulated flags after this item
  } expT;

  logic clk, arstN, instrValid, intResultValid, illegalInstr;
  logic [`ILEN-1:0] instr;
  intWordT intSrc, intResult;
  fflagsT  fflagsSet, fflags;

  fpWordT fregs [`NREGS];   // Register file model
  fflagsT sticky;
  expT    pipe [$];         // Items in flight, oldest first
  int     valueErrors = 0;

  fpuTop dut (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference model helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic isNaN(fpWordT v);
    return &v[30:23] && v[22:0] != '0;
  endfunction

  function automatic logic isSNaN(fpWordT v);
    return isNaN(v) && !v[22];
  endfunction

  // Monotonic key, -0 sorts just below +0
  function automatic logic [31:0] orderKey(fpWordT v);
    return v[31] ? ~v : {1'b1, v[30:0]};
  endfunction

  function automatic logic below(fpWordT a, fpWordT b);  // IEEE a < b
    return (a[30:0] | b[30:0]) != '0 && orderKey(a) < orderKey(b);
  endfunction

  function automatic int classIdx(fpWordT v);   // RISC-V fclass bit
    if (&v[30:23]) begin
      if (v[22:0] == '0) return v[31] ? 0 : 7;
      return v[22] ? 9 : 8;
    end
    if (v[30:23] != '0) return v[31] ? 1 : 6;
    if (v[22:0] != '0)  return v[31] ? 2 : 5;
    return v[31] ? 3 : 4;
  endfunction

  task automatic valueError(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got);
    valueErrors++;
  endtask

  task automatic checkOut(input expT e);
    assert (intResultValid === e.vld)
      else valueError("intResultValid", 32'(e.vld), 32'(intResultValid));
    assert (!e.vld || intResult === e.val) else valueError("intResult", e.val, intResult);
    assert (fflagsSet === e.set) else valueError("fflagsSet", 32'(e.set), 32'(fflagsSet));
    assert (illegalInstr === e.ill)
      else valueError("illegalInstr", 32'(e.ill), 32'(illegalInstr));
    assert (fflags === e.sticky) else valueError("fflags", 32'(e.sticky), 32'(fflags));
  endtask

  //////////////////////////////////////////////////////////////////////
  // One cycle: check the item issued two falling edges ago, then drive
  //////////////////////////////////////////////////////////////////////
  task automatic apply(input logic v, input fpOpE op, input logic [31:0] ins, input intWordT src);
    expT    e;
    fpWordT a, b, w;
    logic   fpw, nv, unord, eqv;
    @(negedge clk);
    if (pipe.size() == 2) checkOut(pipe.pop_front());
    instrValid = v;
    instr      = ins;
    intSrc     = src;
    a     = fregs[ins[19:15]];
    b     = fregs[ins[24:20]];
    e     = '0;
    fpw   = 1'b0;
    nv    = 1'b0;
    w     = src;
    unord = isNaN(a) | isNaN(b);
    eqv   = !unord && (a == b || (a[30:0] | b[30:0]) == '0);   // +0 equals -0
    if (v) begin
      case (op)
        opSgnj:  begin fpw = 1'b1; w = {b[31], a[30:0]}; end
        opSgnjn: begin fpw = 1'b1; w = {~b[31], a[30:0]}; end
        opSgnjx: begin fpw = 1'b1; w = {a[31] ^ b[31], a[30:0]}; end
        opMin, opMax: begin
          fpw = 1'b1;
          nv  = isSNaN(a) | isSNaN(b);
          if (isNaN(a) && isNaN(b)) w = `CANON_NAN;
          else if (isNaN(a))        w = b;
          else if (isNaN(b))        w = a;
          else w = ((orderKey(a) < orderKey(b)) == (op == opMin)) ? a : b;
        end
        opEq:    begin e.vld = 1'b1; e.val = {31'b0, eqv}; nv = isSNaN(a) | isSNaN(b); end
        opLt:    begin e.vld = 1'b1; e.val = {31'b0, !unord && below(a, b)}; nv = unord; end
        opLe: begin
          e.vld = 1'b1;
          e.val = {31'b0, eqv || (!unord && below(a, b))};   // Any NaN gives 0
          nv    = unord;
        end
        opClass: begin e.vld = 1'b1; e.val = intWordT'(1) << classIdx(a); end
        opMvXW:  begin e.vld = 1'b1; e.val = a; end
        opMvWX:  fpw = 1'b1;
        default: e.ill = 1'b1;             // Unsupported encoding
      endcase
      sticky = sticky | {nv, 4'b0};
    end
    e.set    = e.vld ? {nv, 4'b0} : '0;    // Only integer results carry flags out
    e.sticky = sticky;
    if (v && fpw) fregs[ins[11:7]] = w;
    pipe.push_back(e);
  endtask

  task automatic issue(input fpOpE op, input regAdrT rd, rs1, rs2, input intWordT src);
    logic [6:0] f7;
    logic [2:0] f3;
    f3 = 3'd0;
    case (op)
      opSgnj, opSgnjn, opSgnjx: begin f7 = `F7_FSGNJ; f3 = 3'(op - opSgnj); end
      opMin, opMax: begin f7 = `F7_FMINMAX; f3 = 3'(op - opMin); end
      opEq:    begin f7 = `F7_FCMP; f3 = 3'd2; end
      opLt:    begin f7 = `F7_FCMP; f3 = 3'd1; end
      opLe:    f7 = `F7_FCMP;
      opClass: begin f7 = `F7_FMVXW; f3 = 3'd1; end
      opMvXW:  f7 = `F7_FMVXW;
      default: f7 = `F7_FMVWX;
    endcase
    if (op inside {opClass, opMvXW, opMvWX}) rs2 = '0;   // Single-source forms
    apply(1'b1, op, {f7, rs2, rs1, f3, rd, `OPFP}, src);
  endtask

  task automatic resetDut();
    @(negedge clk);
    arstN      = 1'b0;
    instrValid = 1'b0;
    pipe.delete();
    sticky = '0;
    foreach (fregs[i]) fregs[i] = '0;
    repeat (8) @(negedge clk);
    arstN = 1'b1;
    repeat (2) pipe.push_back('0);         // Idle outputs and clear flags
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin
    regAdrT      r, xr, yr;
    logic [31:0] bad [4];
    void'($urandom(40418));
    arstN      = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    intSrc     = '0;
    resetDut();
    for (int i = 0; i < 8; i++) begin      // Write then read back, via bypass
      r = regAdrT'($urandom);
      issue(opMvWX, r, '0, '0, $urandom);
      issue(opMvXW, '0, r, '0, '0);
    end
    issue(opMvWX, 5'd30, '0, '0, 32'h1234_5678);
    issue(opSgnj, 5'd29, 5'd30, 5'd30, '0);
    issue(opMvXW, '0, 5'd30, '0, '0);      // Read after another instruction
    for (int i = 0; i < NSPEC; i++) issue(opMvWX, regAdrT'(i), '0, '0, SPEC[i]);
    issue(opMin, 5'd20, 5'd9, 5'd2, '0);   // sNaN against 1.0 raises sticky NV
    issue(opMvXW, '0, 5'd20, '0, '0);
    for (int i = 0; i < NSPEC; i++) begin
      for (int j = 0; j < NSPEC; j++) begin
        xr = regAdrT'(i);
        yr = regAdrT'(j);
        issue(opSgnj, 5'd20, xr, yr, '0);
        issue(opSgnjn, 5'd21, xr, yr, '0);
        issue(opSgnjx, 5'd22, xr, yr, '0);
        issue(opMin, 5'd23, xr, yr, '0);
        issue(opMax, 5'd24, xr, yr, '0);
        issue(opEq, '0, xr, yr, '0);
        issue(opLt, '0, xr, yr, '0);
        issue(opLe, '0, xr, yr, '0);
        for (int k = 20; k < 25; k++) issue(opMvXW, '0, regAdrT'(k), '0, '0);
      end
    end
    for (int i = 0; i < NSPEC; i++) issue(opClass, '0, regAdrT'(i), '0, '0);
    bad[0] = {7'b0000000, 5'd1, 5'd2, 3'd0, 5'd3, `OPFP};       // fadd.s
    bad[1] = {`F7_FSGNJ, 5'd1, 5'd2, 3'd3, 5'd4, `OPFP};        // Reserved funct3
    bad[2] = {`F7_FMVWX, 5'd1, 5'd0, 3'd0, 5'd5, `OPFP};        // Nonzero rs2
    bad[3] = {`F7_FSGNJ, 5'd1, 5'd2, 3'd0, 5'd6, 7'b0000111};   // Other major opcode
    for (int i = 0; i < 4; i++) begin
      apply(1'b1, opNone, bad[i], '0);
      issue(opMvXW, '0, bad[i][11:7], '0, '0);                  // rd left unchanged
    end
    resetDut();
    issue(opMvXW, '0, 5'd5, '0, '0);       // Cleared by reset
    for (int i = 0; i < NRAND; i++) begin  // Dependent mix on a few registers
      if ($urandom_range(3) == 0) apply(1'b0, opNone, '0, '0);
      issue(fpOpE'(1 + $urandom_range(10)), regAdrT'($urandom_range(7)),
            regAdrT'($urandom_range(7)), regAdrT'($urandom_range(7)),
            $urandom_range(1) ? SPEC[$urandom_range(NSPEC - 1)] : $urandom);
    end
    repeat (2) apply(1'b0, opNone, '0, '0);
    $display("Errors: %0d value, %0d assertion", valueErrors, dut.sva.failCount);
    if (valueErrors == 0 && dut.sva.failCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog, one clock period per step plus a margin
  initial begin
    #(NSTEPS * 20 + 1000);
    $display("Timeout: the run did not finish within %0d ns", NSTEPS * 20 + 1000);
    $display("Result: FAILED");
    $finish;
  end

endmodule
